//--- design/dcache_geom_pkg.sv
// Geometry is fixed at 4 ways of 64-byte lines; only set count and address width vary.
package dcache_geom_pkg;

    // ------------------------------
    // Cache shape.
    // ------------------------------
    localparam int N_WAYS      = 4;
    localparam int WAY_W       = 2;   // Way number width.
    localparam int LINE_BYTES  = 64;
    localparam int LINE_W      = 512;
    localparam int DWORD_W     = 64;
    localparam int OFFSET_W    = 6;   // Byte offset within a line.
    localparam int DWORD_SEL_W = 3;   // Doubleword select within a line.

    // ------------------------------
    // Types.
    // ------------------------------
    typedef logic [WAY_W-1:0] way_t;

    // One line, seen as doublewords or as bytes.
    // Read path and doubleword lanes use the first view, the byte merge the second.
    typedef union packed {
        logic [LINE_W/DWORD_W-1:0][DWORD_W-1:0] dwords;
        logic [LINE_BYTES-1:0][7:0]             bytes;
    } line_t;

    typedef logic [LINE_BYTES-1:0] byte_mask_t;  // One enable per line byte.

endpackage

//--- design/dcache_op_pkg.sv
// Store encodings follow the RISC-V SB/SH/SW/SD size field; misaligned stores are aligned down.
package dcache_op_pkg;

    // ------------------------------
    // Store type.
    // ------------------------------
    typedef enum logic [1:0] {
        ST_BYTE  = 2'd0,
        ST_HALF  = 2'd1,
        ST_WORD  = 2'd2,
        ST_DWORD = 2'd3
    } store_type_t;

    localparam int MAX_STORE_BYTES = 8;  // Widest store lane.

    // ------------------------------
    // Replacement.
    // ------------------------------
    // Tree bits per set, updated on each hit access.
    localparam int PLRU_W = 3;

endpackage

//--- design/dcache_access_if.sv
// Carries one decoded access per cycle; no handshake, all fields are combinational.
`timescale 1ns/1ps

interface dcache_access_if #(
    parameter int SET_COUNT  = 16,
    parameter int ADDR_WIDTH = 64
);
    import dcache_geom_pkg::*;

    localparam int IDX_W = $clog2(SET_COUNT);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - OFFSET_W;

    logic [IDX_W-1:0]       index;       // Set index.
    logic [TAG_W-1:0]       tag;
    logic [DWORD_SEL_W-1:0] dword_sel;   // Doubleword within the line.
    byte_mask_t             byte_mask;   // Store byte enables.
    line_t                  write_line;  // Store data in its lane.

    // ------------------------------
    // Views.
    // ------------------------------
    modport decoder (
        output index, tag, dword_sel, byte_mask, write_line
    );

    modport tag_side (
        input index, tag
    );

    modport data_side (
        input index, dword_sel, byte_mask, write_line
    );

endinterface

//--- design/dcache_addr_decode.sv
// Purely combinational; store offsets are aligned down to the store size, never faulted.
`timescale 1ns/1ps

module dcache_addr_decode #(
    parameter int SET_COUNT  = 16,
    parameter int ADDR_WIDTH = 64
) (
    input  logic [ADDR_WIDTH-1:0]             i_addr,
    input  dcache_op_pkg::store_type_t        i_store_type,
    input  logic [dcache_geom_pkg::DWORD_W-1:0] i_write_data,
    dcache_access_if.decoder                  o_acc
);
    import dcache_geom_pkg::*;
    import dcache_op_pkg::*;

    localparam int IDX_W = $clog2(SET_COUNT);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - OFFSET_W;

    logic [OFFSET_W-1:0]        byte_off;
    logic [OFFSET_W-1:0]        lane_base;   // First byte of the store lane.
    logic [MAX_STORE_BYTES-1:0] small_mask;  // Enables within one doubleword.
    logic [2:0]                 align;
    logic [DWORD_W-1:0]         lane_data;

    // ------------------------------
    // Address split.
    // ------------------------------
    assign o_acc.tag       = i_addr[ADDR_WIDTH-1 -: TAG_W];
    assign o_acc.index     = i_addr[OFFSET_W +: IDX_W];
    assign o_acc.dword_sel = i_addr[OFFSET_W-1 -: DWORD_SEL_W];
    assign byte_off        = i_addr[OFFSET_W-1:0];

    // ------------------------------
    // Store lane.
    // ------------------------------
    always_comb begin
        small_mask = 8'h01;
        align      = 3'd0;
        unique case (i_store_type)
            ST_BYTE:  begin small_mask = 8'h01; align = 3'd0; end
            ST_HALF:  begin small_mask = 8'h03; align = 3'd1; end
            ST_WORD:  begin small_mask = 8'h0f; align = 3'd3; end
            ST_DWORD: begin small_mask = 8'hff; align = 3'd7; end
        endcase

        lane_base = byte_off & ~OFFSET_W'(align);

        // Keep only the low bytes that the store writes.
        for (int b = 0; b < MAX_STORE_BYTES; b++) begin
            lane_data[b*8 +: 8] = small_mask[b] ? i_write_data[b*8 +: 8] : 8'h00;
        end

        o_acc.byte_mask  = byte_mask_t'(small_mask) << lane_base;
        o_acc.write_line = line_t'(LINE_W'(lane_data) << {lane_base, 3'b000});
    end

endmodule

//--- design/dcache_tag_plru.sv
// Stores must hit; refill and write-back sequencing belong to an external miss controller.
`timescale 1ns/1ps

module dcache_tag_plru #(
    parameter int SET_COUNT  = 16,
    parameter int ADDR_WIDTH = 64
) (
    input  logic                  i_clk,
    input  logic                  i_arst,
    input  logic                  i_write_en,
    input  logic                  i_block_we,
    input  logic                  i_mem_access,
    dcache_access_if.tag_side     i_acc,
    output logic                  o_hit,
    output logic                  o_dirty,
    output dcache_geom_pkg::way_t o_hit_way,
    output dcache_geom_pkg::way_t o_victim_way,
    output logic [ADDR_WIDTH-1:0] o_addr_wb
);
    import dcache_geom_pkg::*;
    import dcache_op_pkg::*;

    localparam int IDX_W = $clog2(SET_COUNT);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - OFFSET_W;

    // ------------------------------
    // State arrays.
    // ------------------------------
    logic [TAG_W-1:0]  tag_mem   [SET_COUNT][N_WAYS];
    logic [N_WAYS-1:0] valid_mem [SET_COUNT];
    logic [N_WAYS-1:0] dirty_mem [SET_COUNT];
    logic [PLRU_W-1:0] plru_mem  [SET_COUNT];   // b0 root, b1 ways 0/1, b2 ways 2/3.

    logic [IDX_W-1:0]  idx;
    logic [N_WAYS-1:0] match;
    logic [PLRU_W-1:0] plru;
    logic [TAG_W-1:0]  victim_tag;

    assign idx  = i_acc.index;
    assign plru = plru_mem[idx];

    // ------------------------------
    // Lookup.
    // ------------------------------
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            match[w] = valid_mem[idx][w] && (tag_mem[idx][w] == i_acc.tag);
        end
    end

    assign o_hit        = |match;
    assign o_victim_way = {plru[0], plru[0] ? plru[2] : plru[1]};

    // Lowest matching way wins. Falls back to the victim on a miss.
    always_comb begin
        o_hit_way = o_victim_way;
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                o_hit_way = way_t'(w);
            end
        end
    end

    // An invalid victim has nothing to write back, so its tag reads as zero.
    assign victim_tag = valid_mem[idx][o_victim_way] ? tag_mem[idx][o_victim_way] : '0;
    assign o_dirty    = dirty_mem[idx][o_victim_way];
    assign o_addr_wb  = {victim_tag, idx, OFFSET_W'(0)};

    // ------------------------------
    // Updates.
    // ------------------------------
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end else if (i_write_en) begin
            dirty_mem[idx][o_hit_way] <= 1'b1;     // Store marks the line dirty.
        end else if (i_block_we) begin
            valid_mem[idx][o_victim_way] <= 1'b1;  // Fresh line from memory.
            dirty_mem[idx][o_victim_way] <= 1'b0;
        end
    end

    // Point the tree away from the way just used.
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                plru_mem[s] <= '0;
            end
        end else if (o_hit && i_mem_access) begin
            plru_mem[idx][0] <= ~o_hit_way[1];
            if (o_hit_way[1]) begin
                plru_mem[idx][2] <= ~o_hit_way[0];
            end else begin
                plru_mem[idx][1] <= ~o_hit_way[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_block_we && !i_write_en) begin
            tag_mem[idx][o_victim_way] <= i_acc.tag;
        end
    end

    // ------------------------------
    // Checks.
    // ------------------------------
    a_store_hits: assert property (@(posedge i_clk) disable iff (i_arst)
        i_write_en |-> o_hit);

    a_no_store_refill: assert property (@(posedge i_clk) disable iff (i_arst)
        !(i_write_en && i_block_we));

endmodule

//--- design/dcache_data_array.sv
// Line storage has no reset; contents are undefined until a refill writes the way.
`timescale 1ns/1ps

module dcache_data_array #(
    parameter int SET_COUNT = 16
) (
    input  logic                                i_clk,
    input  logic                                i_write_en,
    input  logic                                i_block_we,
    input  dcache_geom_pkg::line_t              i_data_block,
    dcache_access_if.data_side                  i_acc,
    input  logic                                i_hit,
    input  dcache_geom_pkg::way_t               i_hit_way,
    input  dcache_geom_pkg::way_t               i_victim_way,
    output logic [dcache_geom_pkg::DWORD_W-1:0] o_read_data,
    output dcache_geom_pkg::line_t              o_data_block
);
    import dcache_geom_pkg::*;

    localparam int IDX_W = $clog2(SET_COUNT);

    line_t            mem [SET_COUNT][N_WAYS];
    logic [IDX_W-1:0] idx;
    line_t            cur_line;   // Line of the hit way.
    line_t            merged;     // Line after the store.

    assign idx      = i_acc.index;
    assign cur_line = mem[idx][i_hit_way];

    // ------------------------------
    // Store merge.
    // ------------------------------
    always_comb begin
        merged = cur_line;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (i_acc.byte_mask[b]) begin
                merged.bytes[b] = i_acc.write_line.bytes[b];
            end
        end
    end

    // Store has priority over refill.
    always_ff @(posedge i_clk) begin
        if (i_write_en) begin
            if (i_hit) begin
                mem[idx][i_hit_way] <= merged;
            end
        end else if (i_block_we) begin
            mem[idx][i_victim_way] <= i_data_block;
        end
    end

    // ------------------------------
    // Read and write-back.
    // ------------------------------
    assign o_read_data  = cur_line.dwords[i_acc.dword_sel];  // Doubleword of the hit way.
    assign o_data_block = mem[idx][i_victim_way];            // Whole victim line.

    // The decoder must hand over at least one enabled byte for a hitting store.
    a_store_mask: assert property (@(posedge i_clk)
        (i_write_en && i_hit) |-> (|i_acc.byte_mask));

endmodule

//--- design/dcache_top.sv
// Answers in the same cycle with no wait states; an outside controller sequences misses.
`timescale 1ns/1ps

module dcache_top #(
    parameter int SET_COUNT  = 16,
    parameter int ADDR_WIDTH = 64
) (
    input  logic                                i_clk,
    input  logic                                i_arst,
    input  logic                                i_write_en,    // Store into the hit way.
    input  logic                                i_block_we,    // Refill of the victim way.
    input  logic                                i_mem_access,  // Access that updates PLRU.
    input  logic [1:0]                          i_store_type,
    input  logic [ADDR_WIDTH-1:0]               i_addr,
    input  logic [dcache_geom_pkg::LINE_W-1:0]  i_data_block,
    input  logic [dcache_geom_pkg::DWORD_W-1:0] i_write_data,
    output logic                                o_hit,
    output logic                                o_dirty,
    output logic [ADDR_WIDTH-1:0]               o_addr_wb,
    output logic [dcache_geom_pkg::LINE_W-1:0]  o_data_block,
    output logic [dcache_geom_pkg::DWORD_W-1:0] o_read_data
);
    import dcache_geom_pkg::*;
    import dcache_op_pkg::*;

    way_t hit_way;
    way_t victim_way;

    dcache_access_if #(.SET_COUNT(SET_COUNT), .ADDR_WIDTH(ADDR_WIDTH)) acc_if ();

    // ------------------------------
    // Blocks.
    // ------------------------------
    dcache_addr_decode #(.SET_COUNT(SET_COUNT), .ADDR_WIDTH(ADDR_WIDTH)) u_decode (
        .i_addr       (i_addr),
        .i_store_type (store_type_t'(i_store_type)),
        .i_write_data (i_write_data),
        .o_acc        (acc_if.decoder)
    );

    dcache_tag_plru #(.SET_COUNT(SET_COUNT), .ADDR_WIDTH(ADDR_WIDTH)) u_tags (
        .i_clk        (i_clk),
        .i_arst       (i_arst),
        .i_write_en   (i_write_en),
        .i_block_we   (i_block_we),
        .i_mem_access (i_mem_access),
        .i_acc        (acc_if.tag_side),
        .o_hit        (o_hit),
        .o_dirty      (o_dirty),
        .o_hit_way    (hit_way),
        .o_victim_way (victim_way),
        .o_addr_wb    (o_addr_wb)
    );

    dcache_data_array #(.SET_COUNT(SET_COUNT)) u_data (
        .i_clk        (i_clk),
        .i_write_en   (i_write_en),
        .i_block_we   (i_block_we),
        .i_data_block (line_t'(i_data_block)),
        .i_acc        (acc_if.data_side),
        .i_hit        (o_hit),
        .i_hit_way    (hit_way),
        .i_victim_way (victim_way),
        .o_read_data  (o_read_data),
        .o_data_block (o_data_block)
    );

endmodule

//--- dv/dcache_tb.sv
// Default geometry only (16 sets, 64-bit address); stores go only to lines the model holds.
`timescale 1ns/1ps

module dcache_tb;
    import dcache_geom_pkg::*;

    localparam int          SET_COUNT      = 16;
    localparam int          ADDR_WIDTH     = 64;
    localparam int          IDX_W          = $clog2(SET_COUNT);
    localparam int          TAG_W          = ADDR_WIDTH - IDX_W - OFFSET_W;
    localparam int          CLK_PERIOD     = 20;
    localparam int          RESET_CYCLES   = 16;
    localparam int          N_RANDOM       = 200;
    localparam int          PLANNED_CYCLES = RESET_CYCLES + 100 + 2 * N_RANDOM;
    localparam logic [31:0] SEED           = 32'hd076_f9d6;

    logic                  i_clk;
    logic                  i_arst;
    logic                  i_write_en;
    logic                  i_block_we;
    logic                  i_mem_access;
    logic [1:0]            i_store_type;
    logic [ADDR_WIDTH-1:0] i_addr;
    logic [LINE_W-1:0]     i_data_block;
    logic [DWORD_W-1:0]    i_write_data;
    logic                  o_hit;
    logic                  o_dirty;
    logic [ADDR_WIDTH-1:0] o_addr_wb;
    logic [LINE_W-1:0]     o_data_block;
    logic [DWORD_W-1:0]    o_read_data;

    // Reference model state.
    logic [TAG_W-1:0]  m_tag   [SET_COUNT][N_WAYS];
    logic [N_WAYS-1:0] m_valid [SET_COUNT];
    logic [N_WAYS-1:0] m_dirty [SET_COUNT];
    logic [2:0]        m_plru  [SET_COUNT];   // b0 root, b1 ways 0/1, b2 ways 2/3.
    logic [LINE_W-1:0] m_line  [SET_COUNT][N_WAYS];

    dcache_top #(.SET_COUNT(SET_COUNT), .ADDR_WIDTH(ADDR_WIDTH)) i_dut (
        .i_clk        (i_clk),
        .i_arst       (i_arst),
        .i_write_en   (i_write_en),
        .i_block_we   (i_block_we),
        .i_mem_access (i_mem_access),
        .i_store_type (i_store_type),
        .i_addr       (i_addr),
        .i_data_block (i_data_block),
        .i_write_data (i_write_data),
        .o_hit        (o_hit),
        .o_dirty      (o_dirty),
        .o_addr_wb    (o_addr_wb),
        .o_data_block (o_data_block),
        .o_read_data  (o_read_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ------------------------------
    // Helpers.
    // ------------------------------
    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_WIDTH-1:0] a);
        return a[ADDR_WIDTH-1 -: TAG_W];
    endfunction

    function automatic logic [IDX_W-1:0] addr_set(input logic [ADDR_WIDTH-1:0] a);
        return a[OFFSET_W +: IDX_W];
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_W-1:0] tag,
        input logic [IDX_W-1:0] set, input logic [OFFSET_W-1:0] off);
        return {tag, set, off};
    endfunction

    function automatic logic [TAG_W-1:0] random_tag();
        return TAG_W'({$urandom, $urandom});
    endfunction

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] l;
        for (int k = 0; k < LINE_W / 32; k++) begin
            l[k*32 +: 32] = $urandom;
        end
        return l;
    endfunction

    // Store lane of 1, 2, 4 or 8 bytes, aligned down to its size.
    function automatic logic [LINE_W-1:0] merge_store(input logic [LINE_W-1:0] line,
        input logic [1:0] st, input logic [OFFSET_W-1:0] off, input logic [DWORD_W-1:0] wd);
        logic [LINE_W-1:0] result;
        int                size;
        int                base;

        result = line;
        size   = 1 << st;
        base   = int'(off) & ~(size - 1);
        for (int k = 0; k < size; k++) begin
            result[(base + k) * 8 +: 8] = wd[k*8 +: 8];
        end
        return result;
    endfunction

    // Expected outputs for an address against the current model state.
    function automatic void ref_lookup(
        input  logic [ADDR_WIDTH-1:0] a,
        output logic                  hit,
        output logic [1:0]            hit_way,
        output logic [1:0]            victim,
        output logic                  dirty,
        output logic [DWORD_W-1:0]    rdata,
        output logic [ADDR_WIDTH-1:0] wb_addr,
        output logic [LINE_W-1:0]     wb_line
    );
        logic [IDX_W-1:0] s;
        logic [2:0]       p;
        logic [TAG_W-1:0] vtag;
        int               sel;

        s      = addr_set(a);
        p      = m_plru[s];
        sel    = int'(a[OFFSET_W-1 -: DWORD_SEL_W]);
        victim = {p[0], p[0] ? p[2] : p[1]};
        hit    = 1'b0;
        hit_way = victim;
        for (int w = N_WAYS - 1; w >= 0; w--) begin  // Lowest matching way wins.
            if (m_valid[s][w] && m_tag[s][w] == addr_tag(a)) begin
                hit     = 1'b1;
                hit_way = 2'(w);
            end
        end
        vtag    = m_valid[s][victim] ? m_tag[s][victim] : '0;
        dirty   = m_dirty[s][victim];
        rdata   = m_line[s][hit_way][sel*DWORD_W +: DWORD_W];
        wb_addr = {vtag, s, 6'b000000};
        wb_line = m_line[s][victim];
    endfunction

    function automatic logic model_hits(input logic [ADDR_WIDTH-1:0] a);
        logic                  hit;
        logic [1:0]            hw;
        logic [1:0]            vic;
        logic                  dirty;
        logic [DWORD_W-1:0]    rdata;
        logic [ADDR_WIDTH-1:0] wb_addr;
        logic [LINE_W-1:0]     wb_line;

        ref_lookup(a, hit, hw, vic, dirty, rdata, wb_addr, wb_line);
        return hit;
    endfunction

    function automatic logic [TAG_W-1:0] victim_tag_of(input logic [IDX_W-1:0] s);
        logic                  hit;
        logic [1:0]            hw;
        logic [1:0]            vic;
        logic                  dirty;
        logic [DWORD_W-1:0]    rdata;
        logic [ADDR_WIDTH-1:0] wb_addr;
        logic [LINE_W-1:0]     wb_line;

        ref_lookup(make_addr('0, s, '0), hit, hw, vic, dirty, rdata, wb_addr, wb_line);
        return m_tag[s][vic];
    endfunction

    task automatic report_mismatch(input string name, input logic [LINE_W-1:0] got,
        input logic [LINE_W-1:0] exp);
        $display("CHECK FAILED: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic expect_equal(input string name, input logic [LINE_W-1:0] got,
        input logic [LINE_W-1:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // ------------------------------
    // Model and compare.
    // ------------------------------
    always @(posedge i_clk) begin : model_step
        logic                  hit;
        logic [1:0]            hw;
        logic [1:0]            vic;
        logic                  dirty;
        logic [DWORD_W-1:0]    rdata;
        logic [ADDR_WIDTH-1:0] wb_addr;
        logic [LINE_W-1:0]     wb_line;
        logic [IDX_W-1:0]      s;

        if (i_arst) begin
            for (int k = 0; k < SET_COUNT; k++) begin
                m_valid[k] = '0;
                m_dirty[k] = '0;
                m_plru[k]  = '0;
            end
        end else begin
            ref_lookup(i_addr, hit, hw, vic, dirty, rdata, wb_addr, wb_line);
            s = addr_set(i_addr);
            if (i_write_en) begin
                m_line[s][hw]  = merge_store(m_line[s][hw], i_store_type,
                    i_addr[OFFSET_W-1:0], i_write_data);
                m_dirty[s][hw] = 1'b1;
            end else if (i_block_we) begin
                m_valid[s][vic] = 1'b1;
                m_dirty[s][vic] = 1'b0;
                m_tag[s][vic]   = addr_tag(i_addr);
                m_line[s][vic]  = i_data_block;
            end
            if (hit && i_mem_access) begin
                m_plru[s][0] = ~hw[1];  // Point away from the way just used.
                if (hw[1]) begin
                    m_plru[s][2] = ~hw[0];
                end else begin
                    m_plru[s][1] = ~hw[0];
                end
            end
        end
    end

    always @(posedge i_clk) begin : compare
        logic                  e_hit;
        logic [1:0]            e_hw;
        logic [1:0]            e_vic;
        logic                  e_dirty;
        logic [DWORD_W-1:0]    e_rdata;
        logic [ADDR_WIDTH-1:0] e_wb_addr;
        logic [LINE_W-1:0]     e_wb_line;

        #1;
        if (!i_arst) begin
            ref_lookup(i_addr, e_hit, e_hw, e_vic, e_dirty, e_rdata, e_wb_addr, e_wb_line);
            expect_equal("o_hit", LINE_W'(o_hit), LINE_W'(e_hit));
            expect_equal("o_dirty", LINE_W'(o_dirty), LINE_W'(e_dirty));
            expect_equal("o_addr_wb", LINE_W'(o_addr_wb), LINE_W'(e_wb_addr));
            if (e_hit) begin
                expect_equal("o_read_data", LINE_W'(o_read_data), LINE_W'(e_rdata));
            end
            if (m_valid[addr_set(i_addr)][e_vic]) begin  // Unrefilled lines are unknown.
                expect_equal("o_data_block", o_data_block, e_wb_line);
            end
        end
    end

    // ------------------------------
    // Stimulus.
    // ------------------------------
    task automatic drive(input logic we, input logic bwe, input logic acc,
        input logic [1:0] st, input logic [ADDR_WIDTH-1:0] a,
        input logic [DWORD_W-1:0] wd, input logic [LINE_W-1:0] blk);
        @(posedge i_clk);
        i_write_en   <= we;
        i_block_we   <= bwe;
        i_mem_access <= acc;
        i_store_type <= st;
        i_addr       <= a;
        i_write_data <= wd;
        i_data_block <= blk;
    endtask

    task automatic read_at(input logic [ADDR_WIDTH-1:0] a, input logic acc);
        drive(1'b0, 1'b0, acc, 2'd0, a, '0, '0);
    endtask

    task automatic refill(input logic [ADDR_WIDTH-1:0] a, input logic [LINE_W-1:0] blk);
        drive(1'b0, 1'b1, 1'b0, 2'd0, a, '0, blk);
    endtask

    task automatic store(input logic [ADDR_WIDTH-1:0] a, input logic [1:0] st,
        input logic [DWORD_W-1:0] wd);
        drive(1'b1, 1'b0, 1'b0, st, a, wd, '0);
    endtask

    initial begin : watchdog
        #(2 * PLANNED_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d clock cycles", 2 * PLANNED_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [LINE_W-1:0]     line;
        logic [TAG_W-1:0]      tag;
        logic [TAG_W-1:0]      tags [N_WAYS];
        logic [TAG_W-1:0]      pool [4][6];   // Six tags compete for four ways.
        logic [ADDR_WIDTH-1:0] a;
        int                    s;

        void'($urandom(SEED));
        i_clk        = 1'b0;
        i_arst       <= 1'b1;
        i_write_en   <= 1'b0;
        i_block_we   <= 1'b0;
        i_mem_access <= 1'b0;
        i_store_type <= 2'd0;
        i_addr       <= '0;
        i_data_block <= '0;
        i_write_data <= '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_arst <= 1'b0;

        for (int k = 0; k < 8; k++) begin  // Everything misses after reset.
            read_at(make_addr(random_tag(), IDX_W'($urandom), OFFSET_W'($urandom)), 1'b0);
            #1;
            expect_equal("o_hit", LINE_W'(o_hit), '0);
        end

        // Refill then read back every doubleword.
        tag  = random_tag();
        line = random_line();
        refill(make_addr(tag, IDX_W'(2), '0), line);
        for (int d = 0; d < 8; d++) begin
            read_at(make_addr(tag, IDX_W'(2), OFFSET_W'(d * 8)), 1'b1);
            #1;
            expect_equal("o_hit", LINE_W'(o_hit), LINE_W'(1));
            expect_equal("o_read_data", LINE_W'(o_read_data),
                LINE_W'(line[d*DWORD_W +: DWORD_W]));
        end

        // Stores of each size.
        tag = random_tag();
        refill(make_addr(tag, IDX_W'(5), '0), random_line());
        for (int t = 0; t < 4; t++) begin
            repeat (4) begin
                a = make_addr(tag, IDX_W'(5), OFFSET_W'($urandom & ~((32'd1 << t) - 32'd1)));
                store(a, 2'(t), {$urandom, $urandom});
                read_at(a, 1'b0);
            end
        end
        for (int d = 0; d < 8; d++) begin
            read_at(make_addr(tag, IDX_W'(5), OFFSET_W'(d * 8)), 1'b0);
        end

        // ------------------------------
        // PLRU fill order and write-back.
        // ------------------------------
        tag = random_tag();
        for (int w = 0; w < N_WAYS; w++) begin
            tags[w] = {tag[TAG_W-1:2], 2'(w)};
            refill(make_addr(tags[w], IDX_W'(9), '0), random_line());
            read_at(make_addr(tags[w], IDX_W'(9), '0), 1'b1);
        end
        for (int k = 0; k < N_WAYS; k++) begin
            read_at(make_addr(tags[(k * 3 + 1) % N_WAYS], IDX_W'(9), '0), 1'b1);
        end
        for (int w = 0; w < N_WAYS; w++) begin
            read_at(make_addr(tags[w], IDX_W'(9), '0), 1'b0);
            #1;
            expect_equal("o_hit", LINE_W'(o_hit), LINE_W'(1));
        end
        tag = victim_tag_of(IDX_W'(9));
        store(make_addr(tag, IDX_W'(9), OFFSET_W'($urandom)), 2'd3, {$urandom, $urandom});
        read_at(make_addr(tag, IDX_W'(9), '0), 1'b0);
        #1;
        expect_equal("o_dirty", LINE_W'(o_dirty), LINE_W'(1));
        refill(make_addr(random_tag(), IDX_W'(9), '0), random_line());
        read_at(make_addr(tag, IDX_W'(9), '0), 1'b0);
        #1;
        expect_equal("o_dirty", LINE_W'(o_dirty), '0);

        // Random mix over four sets. Each request is followed by a read.
        for (int p = 0; p < 4; p++) begin
            for (int k = 0; k < 6; k++) begin
                pool[p][k] = random_tag();
            end
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            @(negedge i_clk);
            s = int'($urandom % 4);
            a = make_addr(pool[s][$urandom % 6], IDX_W'(s), OFFSET_W'($urandom));
            if (!model_hits(a)) begin
                refill(a, random_line());
            end else if (($urandom % 3) == 0) begin
                store(a, 2'($urandom), {$urandom, $urandom});
            end else begin
                read_at(a, 1'b1);
            end
            read_at(a, 1'($urandom));
        end

        read_at('0, 1'b0);
        repeat (2) @(posedge i_clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- vlog.f
design/dcache_geom_pkg.sv
design/dcache_op_pkg.sv
design/dcache_access_if.sv
design/dcache_addr_decode.sv
design/dcache_tag_plru.sv
design/dcache_data_array.sv
design/dcache_top.sv
dv/dcache_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dcache_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
